// File: design/exec_isa_pkg.sv
package exec_isa_pkg;

	localparam int ALU_OPC_W = 5;

	localparam logic [ALU_OPC_W-1:0] ALU_OPC_ADD   = 5'h00;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_ADDC  = 5'h01;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_SUB   = 5'h02;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_SUBC  = 5'h03;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_LSL   = 5'h04;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_LSR   = 5'h05;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_AND   = 5'h06;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_XOR   = 5'h07;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_BIC   = 5'h08;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_BST   = 5'h09;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_OR    = 5'h0a;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_COPYB = 5'h0b;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_CMP   = 5'h0c;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_MOVHI = 5'h0d;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_ASR   = 5'h0e;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_MUL   = 5'h0f;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_COPYA = 5'h10;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_SWI   = 5'h11;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_RFE   = 5'h12;
	localparam logic [ALU_OPC_W-1:0] ALU_OPC_GCR   = 5'h13;

	localparam int BRANCH_CC_W = 4;

	// unsigned tests use carry, signed tests use n and o.
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_NE   = 4'b0001;
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_EQ   = 4'b0010;
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_GT   = 4'b0011;
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_LT   = 4'b0100;
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_GTS  = 4'b0101;
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_LTS  = 4'b0110;
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_B    = 4'b0111;
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_GTE  = 4'b1000;
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_GTES = 4'b1001;
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_LTE  = 4'b1010;
	localparam logic [BRANCH_CC_W-1:0] BRANCH_CC_LTES = 4'b1011;

	localparam int CLASS_W = 2;

	localparam logic [CLASS_W-1:0] CLASS_ARITH  = 2'b00;
	localparam logic [CLASS_W-1:0] CLASS_BRANCH = 2'b01;
	localparam logic [CLASS_W-1:0] CLASS_MEM    = 2'b10;

	// results the memory stage can hold.
	localparam int EXEC_CREDITS = 2;
	localparam int CREDIT_W = $clog2(EXEC_CREDITS + 1);

endpackage

// File: design/exec_cr_pkg.sv
package exec_cr_pkg;

	localparam int CR_SEL_W = 3;

	localparam logic [CR_SEL_W-1:0] CR_VECTOR    = 3'd0;
	localparam logic [CR_SEL_W-1:0] CR_PSR       = 3'd1;
	localparam logic [CR_SEL_W-1:0] CR_SAVED_PSR = 3'd2;
	localparam logic [CR_SEL_W-1:0] CR_FAULT     = 3'd3;

	localparam int CR_PSR_RSVD_W = 27;
	localparam int CR_PSR_W = 32 - CR_PSR_RSVD_W;
	localparam int CR_VEC_BASE_W = 26;
	localparam int CR_VEC_OFS_W = 32 - CR_VEC_BASE_W;

	// software interrupt slot in the vector table.
	localparam logic [CR_VEC_OFS_W-1:0] SWI_VECTOR_OFFSET = 6'd8;

	// one control register word, read as status or as vector table address.
	typedef union packed {
		struct packed {
			logic [CR_PSR_RSVD_W-1:0] rsvd;
			logic irqs_enabled;
			logic n;
			logic o;
			logic c;
			logic z;
		} status;
		struct packed {
			logic [CR_VEC_BASE_W-1:0] base;
			logic [CR_VEC_OFS_W-1:0] offset;
		} vector;
	} cr_word_u;

endpackage

// File: design/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
	input  logic [31:0] i_ra,
	input  logic [31:0] i_rb,
	input  logic [31:0] i_imm32,
	input  logic [31:0] i_pc_plus_4,
	input  logic [exec_isa_pkg::ALU_OPC_W-1:0] i_alu_opc,
	input  logic i_op1_ra,
	input  logic i_op1_rb,
	input  logic i_op2_rb,
	input  logic i_carry,
	input  logic [31:0] i_cr_rd_val,
	input  logic [31:0] i_saved_pc,
	input  logic [exec_cr_pkg::CR_VEC_BASE_W-1:0] i_vector_base,
	output logic [31:0] o_result,
	output logic [31:0] o_op2,
	output logic o_c,
	output logic o_z,
	output logic o_n,
	output logic o_o
);

	import exec_isa_pkg::*;
	import exec_cr_pkg::*;

	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] result;
	logic carry;
	logic neg;
	logic ovf;
	cr_word_u swi_word;

	// ra wins over rb, pc is the fallback.
	assign op1 = i_op1_ra ? i_ra : i_op1_rb ? i_rb : i_pc_plus_4;
	assign op2 = i_op2_rb ? i_rb : i_imm32;

	always_comb begin
		swi_word = '0;
		swi_word.vector.base = i_vector_base;
		swi_word.vector.offset = SWI_VECTOR_OFFSET;
	end

	always_comb begin
		result = '0;
		carry = 1'b0;
		neg = 1'b0;
		ovf = 1'b0;

		case (i_alu_opc)
		ALU_OPC_ADD:
			{carry, result} = {1'b0, op1} + {1'b0, op2};
		ALU_OPC_ADDC:
			{carry, result} = {1'b0, op1} + {1'b0, op2} + {32'b0, i_carry};
		ALU_OPC_SUB:
			{carry, result} = {1'b0, op1} - {1'b0, op2};
		ALU_OPC_SUBC:
			{carry, result} = {1'b0, op1} - {1'b0, op2} - {32'b0, i_carry};
		ALU_OPC_MUL:
			{carry, result} = {1'b0, op1} * {1'b0, op2};
		ALU_OPC_LSL:
			{carry, result} = {1'b0, op1} << op2[4:0];
		ALU_OPC_LSR:
			result = op1 >> op2[4:0];
		ALU_OPC_ASR:
			result = $signed(op1) >>> op2[4:0];
		ALU_OPC_AND:
			result = op1 & op2;
		ALU_OPC_OR:
			result = op1 | op2;
		ALU_OPC_XOR:
			result = op1 ^ op2;
		ALU_OPC_BIC:
			result = op1 & ~(32'd1 << op2[4:0]);
		ALU_OPC_BST:
			result = op1 | (32'd1 << op2[4:0]);
		ALU_OPC_CMP: begin
			{carry, result} = {1'b0, op1} - {1'b0, op2};
			// signs differ and the difference took the sign of op2.
			ovf = (op1[31] ^ op2[31]) && (result[31] == op2[31]);
			neg = result[31];
		end
		ALU_OPC_MOVHI:
			result = op1 | {16'b0, op2[15:0]};
		ALU_OPC_COPYA:
			result = op1;
		ALU_OPC_COPYB:
			result = op2;
		ALU_OPC_GCR:
			result = i_cr_rd_val;
		ALU_OPC_SWI:
			result = swi_word;
		ALU_OPC_RFE:
			result = i_saved_pc;
		default:
			result = '0;
		endcase
	end

	assign o_result = result;
	assign o_op2 = op2;
	assign o_c = carry;
	assign o_z = (op1 == op2);
	assign o_n = neg;
	assign o_o = ovf;

endmodule

// File: design/exec_ctrl_regs.sv
`timescale 1ns/1ps

module exec_ctrl_regs (
	input  logic clk,
	input  logic rst,
	input  logic i_accept,
	input  logic [31:0] i_ra,
	input  logic [31:0] i_pc_plus_4,
	input  logic [exec_cr_pkg::CR_SEL_W-1:0] i_cr_sel,
	input  logic i_write_cr,
	input  logic i_update_flags,
	input  logic i_update_carry,
	input  logic i_alu_c,
	input  logic i_alu_z,
	input  logic i_alu_n,
	input  logic i_alu_o,
	input  logic i_is_swi,
	input  logic i_is_rfe,
	input  logic i_irq_start,
	input  logic [31:0] i_irq_fault_address,
	input  logic [exec_isa_pkg::BRANCH_CC_W-1:0] i_branch_cond,
	input  logic [exec_cr_pkg::CR_SEL_W-1:0] i_dbg_cr_sel,
	input  logic i_dbg_cr_wr_en,
	input  logic [31:0] i_dbg_cr_wr_val,
	output logic o_carry,
	output logic [31:0] o_cr_rd_val,
	output logic [31:0] o_saved_pc,
	output logic [exec_cr_pkg::CR_VEC_BASE_W-1:0] o_vector_base,
	output logic o_cond_met,
	output logic o_irqs_enabled,
	output logic [31:0] o_dbg_cr_val
);

	import exec_isa_pkg::*;
	import exec_cr_pkg::*;

	logic flag_z;
	logic flag_c;
	logic flag_n;
	logic flag_o;
	logic irqs_enabled;
	logic [CR_PSR_W-1:0] saved_psr;
	logic [31:0] fault_address;
	logic [CR_VEC_BASE_W-1:0] vector_base;

	logic cpu_wr;
	logic exc_entry;
	cr_word_u ra_word;
	cr_word_u dbg_word;
	cr_word_u vec_word;
	cr_word_u psr_word;
	cr_word_u spsr_word;
	logic [31:0] cr_file [8];

	assign cpu_wr = i_accept && i_write_cr;
	assign exc_entry = i_accept && (i_is_swi || i_irq_start);
	assign ra_word = i_ra;
	assign dbg_word = i_dbg_cr_wr_val;

	always_comb begin
		vec_word = '0;
		vec_word.vector.base = vector_base;
		psr_word = '0;
		psr_word.status.irqs_enabled = irqs_enabled;
		psr_word.status.n = flag_n;
		psr_word.status.o = flag_o;
		psr_word.status.c = flag_c;
		psr_word.status.z = flag_z;
		spsr_word = {{CR_PSR_RSVD_W{1'b0}}, saved_psr};
	end

	// indices past the fault register read as zero.
	always_comb begin
		for (int i = 0; i < 8; i++)
			cr_file[i] = '0;
		cr_file[CR_VECTOR] = vec_word;
		cr_file[CR_PSR] = psr_word;
		cr_file[CR_SAVED_PSR] = spsr_word;
		cr_file[CR_FAULT] = fault_address;
	end

	assign o_cr_rd_val = cr_file[i_cr_sel];
	assign o_dbg_cr_val = cr_file[i_dbg_cr_sel];

	always_ff @(posedge clk) begin
		if (rst)
			vector_base <= '0;
		else if (i_dbg_cr_wr_en && i_dbg_cr_sel == CR_VECTOR)
			vector_base <= dbg_word.vector.base;
		else if (cpu_wr && i_cr_sel == CR_VECTOR)
			vector_base <= ra_word.vector.base;
	end

	always_ff @(posedge clk) begin
		if (rst)
			saved_psr <= '0;
		else if (i_dbg_cr_wr_en && i_dbg_cr_sel == CR_SAVED_PSR)
			saved_psr <= i_dbg_cr_wr_val[CR_PSR_W-1:0];
		else if (exc_entry)
			saved_psr <= psr_word[CR_PSR_W-1:0];
		else if (cpu_wr && i_cr_sel == CR_SAVED_PSR)
			saved_psr <= i_ra[CR_PSR_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (rst)
			fault_address <= '0;
		else if (i_dbg_cr_wr_en && i_dbg_cr_sel == CR_FAULT)
			fault_address <= i_dbg_cr_wr_val;
		else if (i_accept && i_irq_start)
			fault_address <= i_irq_fault_address;
		else if (i_accept && i_is_swi)
			fault_address <= i_pc_plus_4;
		else if (cpu_wr && i_cr_sel == CR_FAULT)
			fault_address <= i_ra;
	end

	// psr write beats rfe, rfe beats flag updates.
	always_ff @(posedge clk) begin
		if (rst) begin
			{irqs_enabled, flag_n, flag_o, flag_c, flag_z} <= '0;
		end else if (i_dbg_cr_wr_en && i_dbg_cr_sel == CR_PSR) begin
			{irqs_enabled, flag_n, flag_o, flag_c, flag_z} <= dbg_word[CR_PSR_W-1:0];
		end else if (cpu_wr && i_cr_sel == CR_PSR) begin
			{irqs_enabled, flag_n, flag_o, flag_c, flag_z} <= ra_word[CR_PSR_W-1:0];
		end else if (i_accept && i_is_rfe) begin
			{irqs_enabled, flag_n, flag_o, flag_c, flag_z} <= saved_psr;
		end else if (i_accept) begin
			if (i_update_flags) begin
				flag_z <= i_alu_z;
				flag_n <= i_alu_n;
				flag_o <= i_alu_o;
			end
			if (i_update_carry)
				flag_c <= i_alu_c;
			if (exc_entry)
				irqs_enabled <= 1'b0;
		end
	end

	always_comb begin
		case (i_branch_cond)
		BRANCH_CC_B:    o_cond_met = 1'b1;
		BRANCH_CC_NE:   o_cond_met = !flag_z;
		BRANCH_CC_EQ:   o_cond_met = flag_z;
		BRANCH_CC_GT:   o_cond_met = !flag_c && !flag_z;
		BRANCH_CC_LT:   o_cond_met = flag_c;
		BRANCH_CC_GTS:  o_cond_met = !flag_z && (flag_n == flag_o);
		BRANCH_CC_LTS:  o_cond_met = flag_n != flag_o;
		BRANCH_CC_GTE:  o_cond_met = !flag_c;
		BRANCH_CC_GTES: o_cond_met = flag_n == flag_o;
		BRANCH_CC_LTE:  o_cond_met = flag_c || flag_z;
		BRANCH_CC_LTES: o_cond_met = (flag_n != flag_o) || flag_z;
		default:        o_cond_met = 1'b0;
		endcase
	end

	assign o_carry = flag_c;
	assign o_saved_pc = fault_address;
	assign o_vector_base = vector_base;
	assign o_irqs_enabled = irqs_enabled;

	a_swi_rfe_excl: assert property (@(posedge clk) disable iff (rst)
		i_accept |-> !(i_is_swi && i_is_rfe));

	// only accepted instructions and debug writes touch state.
	a_idle_stable: assert property (@(posedge clk) disable iff (rst)
		!i_accept && !i_dbg_cr_wr_en |=>
		$stable({irqs_enabled, flag_n, flag_o, flag_c, flag_z,
			saved_psr, fault_address, vector_base}));

endmodule

// File: design/exec_retire.sv
`timescale 1ns/1ps

module exec_retire (
	input  logic clk,
	input  logic rst,
	input  logic i_valid,
	input  logic i_credit_return,
	input  logic [exec_isa_pkg::CLASS_W-1:0] i_instr_class,
	input  logic i_cond_met,
	input  logic i_is_swi,
	input  logic i_is_rfe,
	input  logic i_is_call,
	input  logic i_update_rd,
	input  logic [3:0] i_rd_sel,
	input  logic i_mem_load,
	input  logic i_mem_store,
	input  logic [1:0] i_mem_width,
	input  logic [31:0] i_result,
	input  logic [31:0] i_op2,
	input  logic [31:0] i_rb,
	input  logic [31:0] i_pc_plus_4,
	output logic o_ready,
	output logic o_accept,
	output logic o_res_valid,
	output logic [31:0] o_wr_val,
	output logic o_wr_result,
	output logic [3:0] o_rd_sel,
	output logic o_branch_taken,
	output logic o_mem_load,
	output logic o_mem_store,
	output logic [1:0] o_mem_width,
	output logic [31:0] o_mar,
	output logic [31:0] o_mdr
);

	import exec_isa_pkg::*;

	logic [CREDIT_W-1:0] credits;
	logic accept;

	// ready looks only at the counter.
	assign o_ready = (credits != '0);
	assign accept = i_valid && o_ready;
	assign o_accept = accept;

	always_ff @(posedge clk) begin
		if (rst)
			credits <= CREDIT_W'(EXEC_CREDITS);
		else if (accept && !i_credit_return)
			credits <= credits - 1'b1;
		else if (!accept && i_credit_return)
			credits <= credits + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o_res_valid <= 1'b0;
			o_wr_result <= 1'b0;
			o_branch_taken <= 1'b0;
			o_mem_load <= 1'b0;
			o_mem_store <= 1'b0;
		end else begin
			o_res_valid <= accept;
			o_wr_result <= accept && i_update_rd;
			o_branch_taken <= accept && i_instr_class == CLASS_BRANCH &&
				(i_cond_met || i_is_swi || i_is_rfe);
			o_mem_load <= accept && i_mem_load;
			o_mem_store <= accept && i_mem_store;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			o_rd_sel <= i_rd_sel;
			o_wr_val <= i_is_call ? i_pc_plus_4 :
				i_mem_store ? i_op2 : i_result;
			if (i_mem_load || i_mem_store) begin
				o_mar <= i_result;
				o_mem_width <= i_mem_width;
			end
			if (i_mem_store)
				o_mdr <= i_rb;
		end
	end

	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits <= CREDIT_W'(EXEC_CREDITS));

	// an empty counter must not let a result through.
	a_no_issue_empty: assert property (@(posedge clk) disable iff (rst)
		credits == '0 |=> !o_res_valid);

endmodule

// File: design/exec_top.sv
`timescale 1ns/1ps

module exec_top (
	input  logic clk,
	input  logic rst,
	input  logic i_valid,
	input  logic [31:0] i_ra,
	input  logic [31:0] i_rb,
	input  logic [31:0] i_imm32,
	input  logic [31:0] i_pc_plus_4,
	input  logic [3:0] i_rd_sel,
	input  logic i_update_rd,
	input  logic [exec_isa_pkg::ALU_OPC_W-1:0] i_alu_opc,
	input  logic i_op1_ra,
	input  logic i_op1_rb,
	input  logic i_op2_rb,
	input  logic i_mem_load,
	input  logic i_mem_store,
	input  logic [1:0] i_mem_width,
	input  logic [exec_isa_pkg::BRANCH_CC_W-1:0] i_branch_cond,
	input  logic [exec_isa_pkg::CLASS_W-1:0] i_instr_class,
	input  logic i_is_call,
	input  logic i_update_carry,
	input  logic i_update_flags,
	input  logic [exec_cr_pkg::CR_SEL_W-1:0] i_cr_sel,
	input  logic i_write_cr,
	input  logic i_is_swi,
	input  logic i_is_rfe,
	input  logic i_irq_start,
	input  logic [31:0] i_irq_fault_address,
	output logic o_ready,
	output logic o_irqs_enabled,
	output logic o_res_valid,
	output logic [31:0] o_wr_val,
	output logic o_wr_result,
	output logic [3:0] o_rd_sel,
	output logic o_branch_taken,
	output logic o_mem_load,
	output logic o_mem_store,
	output logic [1:0] o_mem_width,
	output logic [31:0] o_mar,
	output logic [31:0] o_mdr,
	input  logic i_credit_return,
	input  logic [exec_cr_pkg::CR_SEL_W-1:0] i_dbg_cr_sel,
	output logic [31:0] o_dbg_cr_val,
	input  logic i_dbg_cr_wr_en,
	input  logic [31:0] i_dbg_cr_wr_val
);

	logic accept;
	logic carry;
	logic cond_met;
	logic [31:0] cr_rd_val;
	logic [31:0] saved_pc;
	logic [exec_cr_pkg::CR_VEC_BASE_W-1:0] vector_base;
	logic [31:0] alu_result;
	logic [31:0] alu_op2;
	logic alu_c;
	logic alu_z;
	logic alu_n;
	logic alu_o;

	exec_alu u_alu (
		.i_ra(i_ra),
		.i_rb(i_rb),
		.i_imm32(i_imm32),
		.i_pc_plus_4(i_pc_plus_4),
		.i_alu_opc(i_alu_opc),
		.i_op1_ra(i_op1_ra),
		.i_op1_rb(i_op1_rb),
		.i_op2_rb(i_op2_rb),
		.i_carry(carry),
		.i_cr_rd_val(cr_rd_val),
		.i_saved_pc(saved_pc),
		.i_vector_base(vector_base),
		.o_result(alu_result),
		.o_op2(alu_op2),
		.o_c(alu_c),
		.o_z(alu_z),
		.o_n(alu_n),
		.o_o(alu_o)
	);

	exec_ctrl_regs u_ctrl_regs (
		.clk(clk),
		.rst(rst),
		.i_accept(accept),
		.i_ra(i_ra),
		.i_pc_plus_4(i_pc_plus_4),
		.i_cr_sel(i_cr_sel),
		.i_write_cr(i_write_cr),
		.i_update_flags(i_update_flags),
		.i_update_carry(i_update_carry),
		.i_alu_c(alu_c),
		.i_alu_z(alu_z),
		.i_alu_n(alu_n),
		.i_alu_o(alu_o),
		.i_is_swi(i_is_swi),
		.i_is_rfe(i_is_rfe),
		.i_irq_start(i_irq_start),
		.i_irq_fault_address(i_irq_fault_address),
		.i_branch_cond(i_branch_cond),
		.i_dbg_cr_sel(i_dbg_cr_sel),
		.i_dbg_cr_wr_en(i_dbg_cr_wr_en),
		.i_dbg_cr_wr_val(i_dbg_cr_wr_val),
		.o_carry(carry),
		.o_cr_rd_val(cr_rd_val),
		.o_saved_pc(saved_pc),
		.o_vector_base(vector_base),
		.o_cond_met(cond_met),
		.o_irqs_enabled(o_irqs_enabled),
		.o_dbg_cr_val(o_dbg_cr_val)
	);

	exec_retire u_retire (
		.clk(clk),
		.rst(rst),
		.i_valid(i_valid),
		.i_credit_return(i_credit_return),
		.i_instr_class(i_instr_class),
		.i_cond_met(cond_met),
		.i_is_swi(i_is_swi),
		.i_is_rfe(i_is_rfe),
		.i_is_call(i_is_call),
		.i_update_rd(i_update_rd),
		.i_rd_sel(i_rd_sel),
		.i_mem_load(i_mem_load),
		.i_mem_store(i_mem_store),
		.i_mem_width(i_mem_width),
		.i_result(alu_result),
		.i_op2(alu_op2),
		.i_rb(i_rb),
		.i_pc_plus_4(i_pc_plus_4),
		.o_ready(o_ready),
		.o_accept(accept),
		.o_res_valid(o_res_valid),
		.o_wr_val(o_wr_val),
		.o_wr_result(o_wr_result),
		.o_rd_sel(o_rd_sel),
		.o_branch_taken(o_branch_taken),
		.o_mem_load(o_mem_load),
		.o_mem_store(o_mem_store),
		.o_mem_width(o_mem_width),
		.o_mar(o_mar),
		.o_mdr(o_mdr)
	);

endmodule

// File: test/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

	import exec_isa_pkg::*;
	import exec_cr_pkg::*;

	localparam int WAIT_LIMIT = 200;

	typedef struct packed {
		logic [ALU_OPC_W-1:0] opc;
		logic [31:0] ra;
		logic [31:0] rb;
		logic [31:0] imm;
		logic [31:0] pc;
		logic op1_ra;
		logic op1_rb;
		logic op2_rb;
		logic [CLASS_W-1:0] cls;
		logic [BRANCH_CC_W-1:0] cond;
		logic call;
		logic upd_rd;
		logic upd_c;
		logic upd_f;
		logic [CR_SEL_W-1:0] cr_sel;
		logic write_cr;
		logic swi;
		logic rfe;
		logic irq;
		logic [31:0] irq_addr;
		logic load;
		logic store;
		logic [1:0] width;
		logic [31:0] exp_wr;
		logic exp_taken;
		logic [31:0] exp_mar;
		logic [31:0] exp_mdr;
		logic dbg_chk;
		logic [CR_SEL_W-1:0] dbg_sel;
		logic [31:0] exp_dbg;
	} row_t;

	logic clk;
	logic rst;
	logic i_valid;
	logic [31:0] i_ra;
	logic [31:0] i_rb;
	logic [31:0] i_imm32;
	logic [31:0] i_pc_plus_4;
	logic [3:0] i_rd_sel;
	logic i_update_rd;
	logic [ALU_OPC_W-1:0] i_alu_opc;
	logic i_op1_ra;
	logic i_op1_rb;
	logic i_op2_rb;
	logic i_mem_load;
	logic i_mem_store;
	logic [1:0] i_mem_width;
	logic [BRANCH_CC_W-1:0] i_branch_cond;
	logic [CLASS_W-1:0] i_instr_class;
	logic i_is_call;
	logic i_update_carry;
	logic i_update_flags;
	logic [CR_SEL_W-1:0] i_cr_sel;
	logic i_write_cr;
	logic i_is_swi;
	logic i_is_rfe;
	logic i_irq_start;
	logic [31:0] i_irq_fault_address;
	logic i_credit_return;
	logic [CR_SEL_W-1:0] i_dbg_cr_sel;
	logic i_dbg_cr_wr_en;
	logic [31:0] i_dbg_cr_wr_val;
	logic o_ready;
	logic o_irqs_enabled;
	logic o_res_valid;
	logic [31:0] o_wr_val;
	logic o_wr_result;
	logic [3:0] o_rd_sel;
	logic o_branch_taken;
	logic o_mem_load;
	logic o_mem_store;
	logic [1:0] o_mem_width;
	logic [31:0] o_mar;
	logic [31:0] o_mdr;
	logic [31:0] o_dbg_cr_val;

	row_t rows[$];
	int hold_start;
	int owed = 0;
	logic hold_credits = 1'b0;
	logic [15:0] lfsr = 16'd24006;

	exec_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 16'hb400;
		return b;
	endfunction

	function int take_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	// memory stage model. counts results, hands credits back after a random gap.
	initial begin
		forever begin
			@(negedge clk);
			if (o_res_valid)
				owed++;
		end
	end

	initial begin
		int gap;
		gap = 0;
		i_credit_return = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			i_credit_return = 1'b0;
			if (!hold_credits && owed > 0) begin
				if (gap == 0) begin
					i_credit_return = 1'b1;
					owed--;
					gap = take_bits(2);
				end else begin
					gap--;
				end
			end
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	task automatic check_cr(input string name, input cr_word_u got, input cr_word_u exp);
		if (got !== exp)
			fail_run($sformatf(
				"Error: %s got psr 0x%02h vec 0x%07h+0x%02h expected psr 0x%02h vec 0x%07h+0x%02h",
				name, got[CR_PSR_W-1:0], got.vector.base, got.vector.offset,
				exp[CR_PSR_W-1:0], exp.vector.base, exp.vector.offset));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	function automatic row_t alu_row(logic [4:0] opc, logic [31:0] a, logic [31:0] b,
		logic [1:0] fl, logic [31:0] exp);
		row_t r;
		r = '0;
		r.opc = opc;
		r.ra = a;
		r.rb = b;
		r.pc = 32'h100;
		r.op1_ra = 1'b1;
		r.op2_rb = 1'b1;
		r.cls = CLASS_ARITH;
		r.upd_rd = 1'b1;
		r.upd_f = fl[1];
		r.upd_c = fl[0];
		r.exp_wr = exp;
		return r;
	endfunction

	// target is pc plus imm.
	function automatic row_t br_row(logic [3:0] cond, logic taken);
		row_t r;
		r = alu_row(ALU_OPC_ADD, 32'h0, 32'h0, 2'b00, 32'h140);
		r.op1_ra = 1'b0;
		r.op2_rb = 1'b0;
		r.imm = 32'h40;
		r.cls = CLASS_BRANCH;
		r.cond = cond;
		r.upd_rd = 1'b0;
		r.exp_taken = taken;
		return r;
	endfunction

	function automatic row_t cr_row(logic [4:0] opc, logic [2:0] sel, logic [31:0] a,
		logic wr, logic [31:0] exp);
		row_t r;
		r = alu_row(opc, a, 32'h0, 2'b00, exp);
		r.cr_sel = sel;
		r.write_cr = wr;
		return r;
	endfunction

	function automatic row_t with_dbg(row_t r, logic [2:0] sel, logic [31:0] val);
		r.dbg_chk = 1'b1;
		r.dbg_sel = sel;
		r.exp_dbg = val;
		return r;
	endfunction

	task automatic build_table();
		row_t r;
		rows.push_back(alu_row(ALU_OPC_ADD, 32'hfffffff0, 32'h20, 2'b01, 32'h10));
		rows.push_back(alu_row(ALU_OPC_ADDC, 32'h1, 32'h2, 2'b01, 32'h4));
		rows.push_back(alu_row(ALU_OPC_SUB, 32'ha, 32'h3, 2'b00, 32'h7));
		rows.push_back(alu_row(ALU_OPC_SUBC, 32'h10, 32'h1, 2'b00, 32'hf));
		rows.push_back(alu_row(ALU_OPC_MUL, 32'h1234, 32'h10, 2'b00, 32'h12340));
		rows.push_back(alu_row(ALU_OPC_LSL, 32'h80000001, 32'h1, 2'b00, 32'h2));
		rows.push_back(alu_row(ALU_OPC_LSR, 32'h80000000, 32'h4, 2'b00, 32'h08000000));
		rows.push_back(alu_row(ALU_OPC_ASR, 32'h80000000, 32'h4, 2'b00, 32'hf8000000));
		rows.push_back(alu_row(ALU_OPC_AND, 32'hf0f0f0f0, 32'hff00ff00, 2'b00, 32'hf000f000));
		rows.push_back(alu_row(ALU_OPC_OR, 32'hf0f0f0f0, 32'hff00ff00, 2'b00, 32'hfff0fff0));
		rows.push_back(alu_row(ALU_OPC_XOR, 32'hf0f0f0f0, 32'hff00ff00, 2'b00, 32'h0ff00ff0));
		rows.push_back(alu_row(ALU_OPC_BIC, 32'hff, 32'h3, 2'b00, 32'hf7));
		rows.push_back(alu_row(ALU_OPC_BST, 32'h100, 32'h0, 2'b00, 32'h101));
		rows.push_back(alu_row(ALU_OPC_MOVHI, 32'h12340000, 32'habcd5678, 2'b00, 32'h12345678));
		rows.push_back(alu_row(ALU_OPC_COPYA, 32'hcafef00d, 32'h0, 2'b00, 32'hcafef00d));
		// operand 1 taken from rb.
		r = alu_row(ALU_OPC_COPYA, 32'h11111111, 32'h00002222, 2'b00, 32'h00002222);
		r.op1_ra = 1'b0;
		r.op1_rb = 1'b1;
		rows.push_back(r);
		r = alu_row(ALU_OPC_COPYB, 32'h0, 32'h0, 2'b00, 32'h0badbeef);
		r.op2_rb = 1'b0;
		r.imm = 32'h0badbeef;
		rows.push_back(r);
		// 5 below 9 both ways.
		rows.push_back(alu_row(ALU_OPC_CMP, 32'h5, 32'h9, 2'b11, 32'hfffffffc));
		rows.push_back(br_row(BRANCH_CC_NE, 1'b1));
		rows.push_back(br_row(BRANCH_CC_EQ, 1'b0));
		rows.push_back(br_row(BRANCH_CC_GT, 1'b0));
		rows.push_back(br_row(BRANCH_CC_LT, 1'b1));
		rows.push_back(br_row(BRANCH_CC_GTS, 1'b0));
		rows.push_back(br_row(BRANCH_CC_LTS, 1'b1));
		rows.push_back(br_row(BRANCH_CC_LTE, 1'b1));
		// above unsigned, below signed.
		rows.push_back(alu_row(ALU_OPC_CMP, 32'h80000000, 32'h1, 2'b11, 32'h7fffffff));
		rows.push_back(br_row(BRANCH_CC_GT, 1'b1));
		rows.push_back(br_row(BRANCH_CC_LT, 1'b0));
		rows.push_back(br_row(BRANCH_CC_GTS, 1'b0));
		rows.push_back(br_row(BRANCH_CC_LTS, 1'b1));
		rows.push_back(br_row(BRANCH_CC_GTE, 1'b1));
		rows.push_back(br_row(BRANCH_CC_GTES, 1'b0));
		rows.push_back(alu_row(ALU_OPC_CMP, 32'h7, 32'h7, 2'b11, 32'h0));
		rows.push_back(br_row(BRANCH_CC_EQ, 1'b1));
		rows.push_back(br_row(BRANCH_CC_NE, 1'b0));
		rows.push_back(br_row(BRANCH_CC_LTES, 1'b1));
		rows.push_back(br_row(BRANCH_CC_GTS, 1'b0));
		rows.push_back(br_row(BRANCH_CC_B, 1'b1));
		// store writes back the offset, data comes from rb.
		r = alu_row(ALU_OPC_ADD, 32'h1000, 32'hdeadbeef, 2'b00, 32'h20);
		r.op2_rb = 1'b0;
		r.imm = 32'h20;
		r.cls = CLASS_MEM;
		r.store = 1'b1;
		r.width = 2'b10;
		r.exp_mar = 32'h1020;
		r.exp_mdr = 32'hdeadbeef;
		rows.push_back(r);
		r = alu_row(ALU_OPC_ADD, 32'h2000, 32'h0, 2'b00, 32'h2004);
		r.op2_rb = 1'b0;
		r.imm = 32'h4;
		r.cls = CLASS_MEM;
		r.load = 1'b1;
		r.width = 2'b01;
		r.exp_mar = 32'h2004;
		rows.push_back(r);
		r = br_row(BRANCH_CC_B, 1'b1);
		r.call = 1'b1;
		r.upd_rd = 1'b1;
		r.exp_wr = 32'h100;
		rows.push_back(r);
		rows.push_back(with_dbg(cr_row(ALU_OPC_COPYA, CR_VECTOR, 32'h40001000, 1'b1,
			32'h40001000), CR_VECTOR, 32'h40001000));
		rows.push_back(cr_row(ALU_OPC_GCR, CR_VECTOR, 32'h0, 1'b0, 32'h40001000));
		rows.push_back(with_dbg(cr_row(ALU_OPC_COPYA, CR_PSR, 32'h12, 1'b1, 32'h12),
			CR_PSR, 32'h12));
		rows.push_back(cr_row(ALU_OPC_GCR, CR_PSR, 32'h0, 1'b0, 32'h12));
		rows.push_back(with_dbg(cr_row(ALU_OPC_GCR, 3'd5, 32'h0, 1'b0, 32'h0), 3'd6, 32'h0));
		rows.push_back(cr_row(ALU_OPC_COPYA, CR_FAULT, 32'habc0, 1'b1, 32'habc0));
		rows.push_back(cr_row(ALU_OPC_GCR, CR_FAULT, 32'h0, 1'b0, 32'habc0));
		r = alu_row(ALU_OPC_SWI, 32'h0, 32'h0, 2'b00, 32'h40001008);
		r.cls = CLASS_BRANCH;
		r.swi = 1'b1;
		r.pc = 32'h204;
		r.upd_rd = 1'b0;
		r.exp_taken = 1'b1;
		rows.push_back(with_dbg(r, CR_SAVED_PSR, 32'h12));
		rows.push_back(with_dbg(cr_row(ALU_OPC_GCR, CR_PSR, 32'h0, 1'b0, 32'h02),
			CR_FAULT, 32'h204));
		r = alu_row(ALU_OPC_RFE, 32'h0, 32'h0, 2'b00, 32'h204);
		r.cls = CLASS_BRANCH;
		r.rfe = 1'b1;
		r.upd_rd = 1'b0;
		r.exp_taken = 1'b1;
		rows.push_back(with_dbg(r, CR_PSR, 32'h12));
		r = alu_row(ALU_OPC_COPYA, 32'h55, 32'h0, 2'b00, 32'h55);
		r.irq = 1'b1;
		r.irq_addr = 32'h300;
		rows.push_back(with_dbg(r, CR_FAULT, 32'h300));
		rows.push_back(with_dbg(cr_row(ALU_OPC_GCR, CR_SAVED_PSR, 32'h0, 1'b0, 32'h12),
			CR_PSR, 32'h02));
		// rows issued with credits withheld.
		hold_start = rows.size();
		rows.push_back(with_dbg(alu_row(ALU_OPC_CMP, 32'h3, 32'h3, 2'b11, 32'h0), CR_PSR, 32'h01));
		rows.push_back(with_dbg(alu_row(ALU_OPC_CMP, 32'h2, 32'h9, 2'b11, 32'hfffffff9),
			CR_PSR, 32'h0a));
		rows.push_back(with_dbg(alu_row(ALU_OPC_CMP, 32'h9, 32'h2, 2'b11, 32'h7), CR_PSR, 32'h00));
		rows.push_back(br_row(BRANCH_CC_GTE, 1'b1));
		rows.push_back(br_row(BRANCH_CC_LTE, 1'b0));
	endtask

	task automatic drive_row(input row_t r, input int idx);
		i_alu_opc = r.opc;
		i_ra = r.ra;
		i_rb = r.rb;
		i_imm32 = r.imm;
		i_pc_plus_4 = r.pc;
		i_op1_ra = r.op1_ra;
		i_op1_rb = r.op1_rb;
		i_op2_rb = r.op2_rb;
		i_instr_class = r.cls;
		i_branch_cond = r.cond;
		i_is_call = r.call;
		i_update_rd = r.upd_rd;
		i_rd_sel = 4'(idx);
		i_update_carry = r.upd_c;
		i_update_flags = r.upd_f;
		i_cr_sel = r.cr_sel;
		i_write_cr = r.write_cr;
		i_is_swi = r.swi;
		i_is_rfe = r.rfe;
		i_irq_start = r.irq;
		i_irq_fault_address = r.irq_addr;
		i_mem_load = r.load;
		i_mem_store = r.store;
		i_mem_width = r.width;
	endtask

	task automatic issue(input int idx);
		row_t r;
		int waited;
		cr_word_u exp_psr;
		r = rows[idx];
		waited = 0;
		@(posedge clk);
		#1;
		while (!o_ready) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > WAIT_LIMIT)
				fail_run($sformatf("row %0d timed out waiting for o_ready", idx));
		end
		drive_row(r, idx);
		i_valid = 1'b1;
		@(posedge clk);
		#1;
		i_valid = 1'b0;
		check_bit("o_res_valid", o_res_valid, 1'b1);
		check_word("o_wr_val", o_wr_val, r.exp_wr);
		check_bit("o_wr_result", o_wr_result, r.upd_rd);
		if (r.upd_rd)
			check_word("o_rd_sel", {28'b0, o_rd_sel}, 32'(idx[3:0]));
		check_bit("o_branch_taken", o_branch_taken, r.exp_taken);
		check_bit("o_mem_load", o_mem_load, r.load);
		check_bit("o_mem_store", o_mem_store, r.store);
		if (r.load || r.store) begin
			check_word("o_mar", o_mar, r.exp_mar);
			check_word("o_mem_width", {30'b0, o_mem_width}, {30'b0, r.width});
		end
		if (r.store)
			check_word("o_mdr", o_mdr, r.exp_mdr);
		if (r.dbg_chk) begin
			i_dbg_cr_sel = r.dbg_sel;
			#1;
			check_cr("o_dbg_cr_val", o_dbg_cr_val, r.exp_dbg);
			if (r.dbg_sel == CR_PSR) begin
				exp_psr = r.exp_dbg;
				check_bit("o_irqs_enabled", o_irqs_enabled, exp_psr.status.irqs_enabled);
			end
		end
	endtask

	initial begin
		int waited;
		drive_row('0, 0);
		i_valid = 1'b0;
		i_dbg_cr_sel = '0;
		i_dbg_cr_wr_en = 1'b0;
		i_dbg_cr_wr_val = '0;
		rst = 1'b1;
		build_table();
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		check_bit("o_ready", o_ready, 1'b1);
		for (int i = 0; i < hold_start; i++)
			issue(i);

		// debug write lands at the next edge.
		i_dbg_cr_sel = CR_VECTOR;
		i_dbg_cr_wr_val = 32'h80000040;
		i_dbg_cr_wr_en = 1'b1;
		@(posedge clk);
		#1;
		i_dbg_cr_wr_en = 1'b0;
		check_cr("o_dbg_cr_val", o_dbg_cr_val, 32'h80000040);

		waited = 0;
		@(posedge clk);
		@(negedge clk);
		while (owed != 0 || i_credit_return) begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT)
				fail_run("timed out waiting for all credits to come back");
		end
		hold_credits = 1'b1;
		issue(hold_start);
		issue(hold_start + 1);
		check_bit("o_ready", o_ready, 1'b0);

		// third row waits at the input, state must stay put.
		drive_row(rows[hold_start + 2], hold_start + 2);
		i_valid = 1'b1;
		i_dbg_cr_sel = CR_PSR;
		repeat (6) begin
			@(posedge clk);
			#1;
			check_bit("o_res_valid", o_res_valid, 1'b0);
			check_bit("o_ready", o_ready, 1'b0);
			check_cr("o_dbg_cr_val", o_dbg_cr_val, 32'h0a);
		end
		check_word("results_under_hold", owed, EXEC_CREDITS);
		@(negedge clk);
		hold_credits = 1'b0;
		for (int i = hold_start + 2; i < rows.size(); i++)
			issue(i);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: flist.f
design/exec_isa_pkg.sv
design/exec_cr_pkg.sv
design/exec_alu.sv
design/exec_ctrl_regs.sv
design/exec_retire.sv
design/exec_top.sv
test/exec_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module exec_tb -f flist.f -o exec_sim \
	&& ./obj_dir/exec_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
